//--- common/mmm_params.svh
/*
  Size and width macros for the limb multiplier
*/
`ifndef MMM_PARAMS_SVH
`define MMM_PARAMS_SVH

// Number of limbs in each input operand
`define MMM_NUM_LIMBS 4

// Stored limb width, one bit wider than the weight step for redundant form
`define MMM_LIMB_BITS 17

// Weight step between neighbouring limbs
`define MMM_WORD_BITS 16

// Limb product plus one bit for square-mode doubling
`define MMM_PROD_BITS (2 * `MMM_LIMB_BITS + 1)

// Column sum width
// High part of a product plus 3 bits of headroom for the column height
`define MMM_COL_BITS (`MMM_PROD_BITS - `MMM_WORD_BITS + 3)

`endif

//--- common/mmm_pkg.sv
/*
  Shared types of the limb multiplier
  Opcode enum, operand vectors, request, row product and result
*/
`include "mmm_params.svh"

package mmm_pkg;

  // Multiplier opcode
  typedef enum logic [1:0] {
    OP_MUL = 2'd0,  // A * B + C
    OP_SQR = 2'd1   // A * A + C, B ignored
  } mul_op_e;

  // One limb in redundant form
  typedef logic [`MMM_LIMB_BITS-1:0] limb_t;

  // One limb product, doubled in square mode off the diagonal
  typedef logic [`MMM_PROD_BITS-1:0] prod_t;

  // Operand vector, limb i carries weight 2^(16*i)
  typedef limb_t [`MMM_NUM_LIMBS-1:0] limb_vec_t;

  // Request as seen at the top level and after routing
  typedef struct packed {
    mul_op_e   op;
    limb_vec_t a;
    limb_vec_t b;
    limb_vec_t add;
  } mul_req_t;

  // Products of one row
  // Addition term travels along so it stays aligned with the products
  typedef struct packed {
    mul_op_e                      op;
    prod_t [`MMM_NUM_LIMBS-1:0] prod;
    limb_vec_t                    add;
  } row_prod_t;

  // Double-length result in the same redundant form
  typedef limb_t [2*`MMM_NUM_LIMBS-1:0] result_t;

endpackage

//--- hdl/operand_router.sv
/*
  Feeder stage
  Registers the request and routes the B operand for the opcode
*/
`timescale 1ns/1ps

module operand_router (
  input                     i_clk,
  input                     i_rst,
  input                     i_valid,
  input  mmm_pkg::mul_req_t i_req,
  output logic              o_valid,
  output mmm_pkg::mul_req_t o_req
);

  import mmm_pkg::*;

  limb_vec_t routed_b;

  // Squaring feeds A on both sides so every row sees one operand pair
  always_comb begin
    if (i_req.op == OP_SQR) begin
      routed_b = i_req.a;
    end else begin
      routed_b = i_req.b;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // Operands only load on a strobe
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_req.op  <= i_req.op;
      o_req.a   <= i_req.a;
      o_req.b   <= routed_b;
      o_req.add <= i_req.add;
    end
  end

endmodule

//--- multiplier/limb_product_row.sv
/*
  One row of limb products
  Limb ROW of A times every limb of B, triangle skip and doubling for squares
*/
`timescale 1ns/1ps
`include "mmm_params.svh"

module limb_product_row #(
  parameter int ROW = 0
) (
  input                      i_clk,
  input                      i_rst,
  input                      i_valid,
  input  mmm_pkg::mul_req_t  i_req,
  output logic               o_valid,
  output mmm_pkg::row_prod_t o_row
);

  import mmm_pkg::*;

  localparam int NL = `MMM_NUM_LIMBS;

  prod_t [NL-1:0] prod_d;

  always_comb begin
    logic [2*`MMM_LIMB_BITS-1:0] full;
    for (int j = 0; j < NL; j++) begin
      full = i_req.a[ROW] * i_req.b[j];
      if (i_req.op == OP_SQR && j < ROW) begin
        // Mirrored pair in row j already covers this one, doubled
        prod_d[j] = '0;
      end else if (i_req.op == OP_SQR && j > ROW) begin
        prod_d[j] = {full, 1'b0};
      end else begin
        prod_d[j] = {1'b0, full};
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_row.op   <= i_req.op;
      o_row.prod <= prod_d;
      o_row.add  <= i_req.add;
    end
  end

endmodule

//--- multiplier/column_reducer.sv
/*
  Drain stage
  Splits products into columns, adds the addition term, sums each column,
  runs one carry pass and registers the result
*/
`timescale 1ns/1ps
`include "mmm_params.svh"

module column_reducer (
  input                          i_clk,
  input                          i_rst,
  input                          i_valid,
  input  mmm_pkg::row_prod_t     i_rows [`MMM_NUM_LIMBS],
  output logic                   o_valid,
  output mmm_pkg::result_t       o_result
);

  import mmm_pkg::*;

  localparam int NL = `MMM_NUM_LIMBS;
  localparam int NC = 2 * `MMM_NUM_LIMBS;
  localparam int LB = `MMM_LIMB_BITS;
  localparam int WB = `MMM_WORD_BITS;
  localparam int PB = `MMM_PROD_BITS;
  localparam int CB = `MMM_COL_BITS;

  // Zero padding from each term width up to the column width
  localparam int LO_PAD  = CB - WB;
  localparam int HI_PAD  = CB - (PB - WB);
  localparam int ADD_PAD = CB - LB;

  // Padding of a column carry up to a limb
  localparam int CY_PAD = LB - (CB - WB);

  logic [CB-1:0] col_sum [NC];
  result_t       carry_d;

  // Column sums
  // Low half of product (r,j) lands in column r+j, the rest in column r+j+1
  always_comb begin
    for (int k = 0; k < NC; k++) begin
      col_sum[k] = '0;
    end

    for (int r = 0; r < NL; r++) begin
      for (int j = 0; j < NL; j++) begin
        col_sum[r+j] = col_sum[r+j] +
                       {{LO_PAD{1'b0}}, i_rows[r].prod[j][WB-1:0]};
        col_sum[r+j+1] = col_sum[r+j+1] +
                         {{HI_PAD{1'b0}}, i_rows[r].prod[j][PB-1:WB]};
      end
    end

    // All rows carry the same addition term, row 0 is taken
    for (int i = 0; i < NL; i++) begin
      col_sum[i] = col_sum[i] + {{ADD_PAD{1'b0}}, i_rows[0].add[i]};
    end
  end

  // Single carry pass
  // Each limb keeps its low 16 bits plus the overflow of the column below
  always_comb begin
    carry_d[0] = {1'b0, col_sum[0][WB-1:0]};
    for (int k = 1; k < NC; k++) begin
      carry_d[k] = {1'b0, col_sum[k][WB-1:0]} +
                   {{CY_PAD{1'b0}}, col_sum[k-1][CB-1:WB]};
    end
    // Overflow of the top column falls outside the result width
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_result <= carry_d;
    end
  end

endmodule

//--- hdl/mmm_top.sv
/*
  Limb multiplier top level
  Router, one product row per A limb, column reducer
*/
`timescale 1ns/1ps
`include "mmm_params.svh"

module mmm_top (
  input                     i_clk,
  input                     i_rst,
  input                     i_valid,
  input  mmm_pkg::mul_req_t i_req,
  output logic              o_valid,
  output mmm_pkg::result_t  o_result
);

  import mmm_pkg::*;

  localparam int NL = `MMM_NUM_LIMBS;

  logic            route_valid;
  mul_req_t        route_req;
  logic [NL-1:0]   row_valid;
  row_prod_t       rows [NL];

  // Stage 1
  operand_router u_router (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_valid (route_valid),
    .o_req   (route_req)
  );

  // Stage 2, one row per limb of A
  for (genvar r = 0; r < NL; r++) begin : g_row
    limb_product_row #(
      .ROW (r)
    ) u_row (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_valid (route_valid),
      .i_req   (route_req),
      .o_valid (row_valid[r]),
      .o_row   (rows[r])
    );
  end

  // Stage 3, rows share one timing so row 0 valid stands for all
  column_reducer u_reducer (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (row_valid[0]),
    .i_rows   (rows),
    .o_valid  (o_valid),
    .o_result (o_result)
  );

endmodule

//--- bench/mmm_tb.sv
/*
  Testbench for the limb multiplier top level
  Stimulus table with expected values, value-based reference model,
  result and latency checks, watchdog
*/
`timescale 1ns/1ps
`include "mmm_params.svh"

module mmm_tb;

  import mmm_pkg::*;

  localparam int NL          = `MMM_NUM_LIMBS;
  localparam int WB          = `MMM_WORD_BITS;
  localparam int NUM_TESTS   = 40;
  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 16;
  localparam int LATENCY     = 3;
  localparam int DRAIN_LIMIT = 10;
  localparam int VW          = 256;
  localparam int MOD_BITS    = 32 * NL;
  localparam int WATCHDOG_NS = (RST_CYCLES + NUM_TESTS * 4 + 10) * CLK_PERIOD;

  localparam logic [VW-1:0] MOD_MASK = {{(VW-MOD_BITS){1'b0}}, {MOD_BITS{1'b1}}};

  logic     i_clk;
  logic     i_rst;
  logic     i_valid;
  mul_req_t i_req;
  logic     o_valid;
  result_t  o_result;

  // Stimulus table with the expected result value of each entry
  mul_op_e       tbl_op  [NUM_TESTS];
  limb_vec_t     tbl_a   [NUM_TESTS];
  limb_vec_t     tbl_b   [NUM_TESTS];
  limb_vec_t     tbl_add [NUM_TESTS];
  int            tbl_gap [NUM_TESTS];
  logic [VW-1:0] tbl_exp [NUM_TESTS];

  int stim_idx;
  int cyc;
  int strobes;
  int results;
  int errors;
  int pend_idx [$];
  int pend_cyc [$];

  mmm_top i_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_req    (i_req),
    .o_valid  (o_valid),
    .o_result (o_result)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // Value of an operand where limb i weighs 2^(16*i)
  function automatic logic [VW-1:0] vec_value(limb_vec_t v);
    logic [VW-1:0] acc;
    acc = '0;
    for (int i = 0; i < NL; i++) begin
      acc = acc + (VW'(v[i]) << (WB * i));
    end
    return acc;
  endfunction

  function automatic logic [VW-1:0] result_value(result_t r);
    logic [VW-1:0] acc;
    acc = '0;
    for (int k = 0; k < 2 * NL; k++) begin
      acc = acc + (VW'(r[k]) << (WB * k));
    end
    return acc & MOD_MASK;
  endfunction

  // Reference value A*B + C or A*A + C modulo 2^(32*NL)
  // B plays no part in the square case
  function automatic logic [VW-1:0] expected_value(mul_op_e op, limb_vec_t a,
                                                   limb_vec_t b, limb_vec_t add);
    logic [VW-1:0] va;
    logic [VW-1:0] vb;
    va = vec_value(a);
    vb = (op == OP_SQR) ? va : vec_value(b);
    return (va * vb + vec_value(add)) & MOD_MASK;
  endfunction

  function automatic limb_vec_t random_vec();
    limb_vec_t v;
    for (int i = 0; i < NL; i++) begin
      v[i] = limb_t'($urandom);
    end
    return v;
  endfunction

  task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      tbl_op[t]  = ($urandom % 32'd2 == 0) ? OP_MUL : OP_SQR;
      tbl_a[t]   = random_vec();
      tbl_b[t]   = random_vec();
      tbl_add[t] = random_vec();
      // First entries go back to back
      tbl_gap[t] = (t < 8) ? 0 : int'($urandom % 32'd3);
    end
    // Corner entries
    tbl_op[0] = OP_MUL;
    tbl_a[0]  = '0;
    tbl_b[0]  = '0;
    tbl_add[0] = '0;
    tbl_op[1] = OP_MUL;
    tbl_a[1]  = '1;
    tbl_b[1]  = '1;
    tbl_add[1] = '1;
    tbl_op[2] = OP_SQR;
    tbl_a[2]  = '1;
    tbl_add[2] = '1;
    // Addition term alone with B random in the square case
    tbl_op[3] = OP_MUL;
    tbl_a[3]  = '0;
    tbl_b[3]  = '0;
    tbl_op[4] = OP_SQR;
    tbl_a[4]  = '0;
    // Single bit in the top limb
    tbl_op[5] = OP_MUL;
    tbl_a[5]  = '0;
    tbl_b[5]  = '0;
    tbl_a[5][NL-1] = 17'h10000;
    tbl_b[5][NL-1] = 17'h10000;
    tbl_add[5] = '0;
    tbl_op[6] = OP_SQR;
    tbl_a[6]  = '0;
    tbl_a[6][NL-1] = 17'h00001;
    tbl_add[6] = '0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      tbl_exp[t] = expected_value(tbl_op[t], tbl_a[t], tbl_b[t], tbl_add[t]);
    end
  endtask

  // Compares one result against the oldest pending request
  task automatic check_result();
    int            idx;
    int            sent;
    logic          ok;
    logic [VW-1:0] got;
    assert (pend_idx.size() != 0) else begin
      $display("Unexpected result at %0t ns: o_valid high with no request pending", $time);
      errors++;
    end
    if (pend_idx.size() != 0) begin
      idx  = pend_idx.pop_front();
      sent = pend_cyc.pop_front();
      got  = result_value(o_result);
      ok   = 1'b1;
      results++;
      assert (got == tbl_exp[idx]) else begin
        $display("MISMATCH at %0t ns: o_result (test %0d) got %h expected %h",
                 $time, idx, got[MOD_BITS-1:0], tbl_exp[idx][MOD_BITS-1:0]);
        ok = 1'b0;
        errors++;
      end
      assert (cyc - sent == LATENCY) else begin
        $display("MISMATCH at %0t ns: o_valid latency (test %0d) got %0d expected %0d",
                 $time, idx, cyc - sent, LATENCY);
        ok = 1'b0;
        errors++;
      end
      $display("test %0d %s: %s", idx, tbl_op[idx].name(), ok ? "ok" : "FAIL");
    end
  endtask

  // Monitor on the falling edge where DUT outputs are stable
  always @(negedge i_clk) begin
    cyc = cyc + 1;
    if (!i_rst) begin
      if (o_valid) begin
        check_result();
      end
      if (i_valid) begin
        pend_idx.push_back(stim_idx);
        pend_cyc.push_back(cyc);
        strobes++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic idle_ok;
    int   wait_cnt;
    void'($urandom(32'h8ec8));
    i_clk    = 1'b0;
    i_rst    = 1'b1;
    i_valid  = 1'b0;
    i_req    = '0;
    stim_idx = 0;
    cyc      = 0;
    strobes  = 0;
    results  = 0;
    errors   = 0;
    idle_ok  = 1'b1;
    build_table();

    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst <= 1'b0;

    // No result may appear before the first request
    repeat (4) begin
      @(negedge i_clk);
      assert (o_valid === 1'b0) else begin
        $display("MISMATCH at %0t ns: o_valid got %b expected 0", $time, o_valid);
        idle_ok = 1'b0;
        errors++;
      end
    end
    $display("test idle after reset: %s", idle_ok ? "ok" : "FAIL");

    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge i_clk);
      i_valid    <= 1'b1;
      i_req.op   <= tbl_op[t];
      i_req.a    <= tbl_a[t];
      i_req.b    <= tbl_b[t];
      i_req.add  <= tbl_add[t];
      stim_idx   <= t;
      for (int g = 0; g < tbl_gap[t]; g++) begin
        @(posedge i_clk);
        i_valid <= 1'b0;
      end
    end
    @(posedge i_clk);
    i_valid <= 1'b0;

    // Drain the pipeline and then watch for stray results
    wait_cnt = 0;
    while (pend_idx.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge i_clk);
      wait_cnt++;
    end
    repeat (4) @(negedge i_clk);

    assert (results == strobes) else begin
      $display("Results missing: only %0d of %0d requests produced a result",
               results, strobes);
      errors++;
    end

    $display("Summary: %0d requests, %0d results, %0d errors", strobes, results, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/mmm_pkg.sv
hdl/operand_router.sv
multiplier/limb_product_row.sv
multiplier/column_reducer.sv
hdl/mmm_top.sv
bench/mmm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the limb multiplier testbench with Verilator and runs it
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=mmm_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f vlog.f --top-module mmm_tb -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
